// File: all.f
+incdir+tb
verilog/rta_geom_pkg.sv
verilog/rta_host_pkg.sv
verilog/mem_main.sv
verilog/stack_fill.sv
verilog/mem_controller.sv
verilog/rta.sv
tb/tb_clk_gen.sv
tb/rta_tb.sv

// File: Bender.yml
package:
  name: rta_mem

sources:
  - files:
      - verilog/rta_geom_pkg.sv
      - verilog/rta_host_pkg.sv
      - verilog/mem_main.sv
      - verilog/stack_fill.sv
      - verilog/mem_controller.sv
      - verilog/rta.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_clk_gen.sv
      - tb/rta_tb.sv

// File: tb/rta_tb_tasks.svh
// Testbench MMIO and test tasks
`ifndef RTA_TB_TASKS_SVH
`define RTA_TB_TASKS_SVH

// ========================================
// Random source and compares
// ========================================

// Plain 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_line(input string name, input line_t got, input line_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_word(input string name, input mmio_data_t got, input mmio_data_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_count(input string name, input line_cnt_t got, input line_cnt_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %s got %h expected %h", name, got, exp);
  end
endtask

// ========================================
// MMIO access
// ========================================

// One-cycle write strobe
task automatic mmio_write(input mmio_addr_t addr, input mmio_data_t data);
  @(posedge clk);
  mmio_wr_en   <= 1'b1;
  mmio_wr_addr <= addr;
  mmio_wr_data <= data;
  @(posedge clk);
  mmio_wr_en <= 1'b0;
endtask

// Data expected exactly one cycle after the request
task automatic mmio_read(input mmio_addr_t addr, output mmio_data_t data);
  @(posedge clk);
  mmio_rd_en   <= 1'b1;
  mmio_rd_addr <= addr;
  @(negedge clk);
  if (mmio_rd_valid !== 1'b0) begin
    errors++;
    $display("MMIO read valid was high before the request was taken");
  end
  @(posedge clk);
  mmio_rd_en <= 1'b0;
  @(negedge clk);
  if (mmio_rd_valid !== 1'b1) begin
    errors++;
    $display("MMIO read valid missing one cycle after the request");
  end
  data = mmio_rd_data;
endtask

// Poll status until done or the poll limit
task automatic wait_done(output mmio_data_t st);
  int polls;
  polls = 0;
  st = '0;
  while (!st[ST_DONE] && polls < POLL_LIMIT) begin
    mmio_read(REG_STATUS, st);
    polls++;
  end
  if (!st[ST_DONE]) begin
    errors++;
    $display("Job did not finish within %0d status polls", POLL_LIMIT);
  end
endtask

// ========================================
// Job run and result check
// ========================================

task automatic run_job(input host_addr_t rd_addr, input host_addr_t wr_addr,
                       input line_cnt_t size);
  mmio_data_t st;
  line_cnt_t  rd_go_before;
  line_cnt_t  wr_go_before;
  line_cnt_t  wb_lines;
  rd_go_before = rd_go_cnt;
  wr_go_before = wr_go_cnt;
  // Loaded lines then every frame of every bank
  wb_lines = size + line_cnt_t'(NUM_RT * FILL_LINES);
  mmio_write(REG_RD_ADDR, mmio_data_t'(rd_addr));
  mmio_write(REG_WR_ADDR, mmio_data_t'(wr_addr));
  mmio_write(REG_SIZE, mmio_data_t'(size));
  mmio_write(REG_GO, 32'h0);
  // Old done and error must be gone
  mmio_read(REG_STATUS, st);
  check_word("status after go", st, '0);
  wait_done(st);
  check_word("status", st, STATUS_DONE);
  check_count("dma_rd_go pulses", line_cnt_t'(rd_go_cnt - rd_go_before), 16'd1);
  check_count("dma_wr_go pulses", line_cnt_t'(wr_go_cnt - wr_go_before), 16'd1);
  check_word("dma_rd_addr", mmio_data_t'(rd_addr_seen), mmio_data_t'(rd_addr));
  check_count("dma_rd_size", rd_size_seen, size);
  check_count("lines read", rd_pos, size);
  check_word("dma_wr_addr", mmio_data_t'(wr_addr_seen), mmio_data_t'(wr_addr));
  check_count("dma_wr_size", wr_size_seen, wb_lines);
  check_count("lines written", sink_cnt, wb_lines);
  // Source lines come back in load order
  for (int n = 0; n < int'(size); n++) begin
    check_line($sformatf("sink[%0d]", n), sink[n], src[src_idx_t'(rd_addr + host_addr_t'(n))]);
  end
  // Frame j holds j
  for (int j = 0; j < NUM_RT * FILL_LINES; j++) begin
    check_line($sformatf("sink[%0d]", int'(size) + j), sink[int'(size) + j], line_t'(j));
  end
endtask

// Rejected size gives status at once and no DMA
task automatic reject_size(input line_cnt_t size);
  mmio_data_t st;
  line_cnt_t  rd_go_before;
  line_cnt_t  wr_go_before;
  rd_go_before = rd_go_cnt;
  wr_go_before = wr_go_cnt;
  mmio_write(REG_SIZE, mmio_data_t'(size));
  mmio_write(REG_GO, 32'h0);
  mmio_read(REG_STATUS, st);
  check_word("status on bad size", st, STATUS_DONE | STATUS_ERR);
  repeat (4) @(posedge clk);
  check_count("dma_rd_go pulses", line_cnt_t'(rd_go_cnt - rd_go_before), 16'd0);
  check_count("dma_wr_go pulses", line_cnt_t'(wr_go_cnt - wr_go_before), 16'd0);
endtask

// ========================================
// Directed tests
// ========================================

task automatic register_readback();
  mmio_data_t rd;
  mmio_read(REG_STATUS, rd);
  check_word("status after reset", rd, '0);
  mmio_write(REG_RD_ADDR, 32'hdead_0123);
  mmio_read(REG_RD_ADDR, rd);
  check_word("rd_addr register", rd, 32'hdead_0123);
  mmio_write(REG_WR_ADDR, 32'h0bad_c0de);
  mmio_read(REG_WR_ADDR, rd);
  check_word("wr_addr register", rd, 32'h0bad_c0de);
  mmio_write(REG_SIZE, 32'h0000_a5c3);
  mmio_read(REG_SIZE, rd);
  check_word("size register", rd, 32'h0000_a5c3);
  // Unmapped offset
  mmio_read(4'hf, rd);
  check_word("unmapped register", rd, '0);
endtask

task automatic basic_job();
  run_job(32'h0000_0005, 32'h0000_0100, 16'd8);
endtask

task automatic full_load_job();
  run_job(32'h0000_0010, 32'h0000_1000, MAX_LOAD);
endtask

// Random empty and full with a source that wraps around
task automatic stressed_job();
  @(posedge clk);
  stress <= 1'b1;
  run_job(32'h0000_003a, 32'h0000_0200, 16'd13);
  @(posedge clk);
  stress <= 1'b0;
endtask

task automatic illegal_sizes();
  reject_size(16'd0);
  reject_size(MAX_LOAD + 16'd1);
endtask

task automatic back_to_back_jobs();
  run_job(32'h0000_0030, 32'h0000_0400, 16'd8);
  run_job(32'h0000_0009, 32'h0000_0800, 16'd8);
endtask

`endif

// File: tb/rta_tb.sv
// Accelerator memory core testbench
`default_nettype none
`timescale 1ns/10ps

module rta_tb;

  import rta_geom_pkg::*;
  import rta_host_pkg::*;

  // ========================================
  // Run limits
  // ========================================

  localparam int RESET_CYCLES   = 10;
  localparam int POLL_LIMIT     = 400;
  // Rough per-job overhead and per-line cost
  localparam int JOB_FIXED      = 80;
  localparam int LINE_CYCLES    = 6;
  localparam int REG_CYCLES     = 60;
  localparam int ILLEGAL_CYCLES = 60;
  // Load plus writeback lines per job with the stress job counted twice
  localparam int JOB_LINES = 3 * (2 * 8 + FILL_TOTAL) + (2 * 32 + FILL_TOTAL) +
                             2 * (2 * 13 + FILL_TOTAL);
  localparam int TEST_CYCLES = RESET_CYCLES + REG_CYCLES + ILLEGAL_CYCLES +
                               5 * JOB_FIXED + LINE_CYCLES * JOB_LINES;
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

  localparam int SRC_DEPTH  = 64;
  localparam int SINK_DEPTH = 64;
  localparam mmio_data_t STATUS_DONE = mmio_data_t'(1) << ST_DONE;
  localparam mmio_data_t STATUS_ERR  = mmio_data_t'(1) << ST_ERR;

  typedef logic [5:0] src_idx_t;

  // ========================================
  // DUT signals
  // ========================================

  logic       clk;
  logic       rst_n;
  logic       mmio_wr_en;
  mmio_addr_t mmio_wr_addr;
  mmio_data_t mmio_wr_data;
  logic       mmio_rd_en;
  mmio_addr_t mmio_rd_addr;
  mmio_data_t mmio_rd_data;
  logic       mmio_rd_valid;
  logic       dma_rd_go;
  host_addr_t dma_rd_addr;
  line_cnt_t  dma_rd_size;
  logic       dma_rd_en;
  logic       dma_rd_empty;
  line_t      dma_rd_data;
  logic       dma_wr_go;
  host_addr_t dma_wr_addr;
  line_cnt_t  dma_wr_size;
  logic       dma_wr_en;
  logic       dma_wr_full;
  line_t      dma_wr_data;
  logic       dma_wr_done;

  // DMA model state
  line_t      src [SRC_DEPTH];
  line_t      sink [SINK_DEPTH];
  logic [31:0] rng = 32'h3776_210f;
  logic       stress = 1'b0;
  host_addr_t rd_base = '0;
  line_cnt_t  rd_pos = '0;
  line_cnt_t  rd_left = '0;
  line_cnt_t  rd_go_cnt = '0;
  line_cnt_t  wr_go_cnt = '0;
  line_cnt_t  sink_cnt = '0;
  host_addr_t rd_addr_seen = '0;
  line_cnt_t  rd_size_seen = '0;
  host_addr_t wr_addr_seen = '0;
  line_cnt_t  wr_size_seen = '0;

  int errors = 0;
  int checks = 0;

  `include "rta_tb_tasks.svh"

  tb_clk_gen clk_gen0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rta dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .mmio_wr_en    (mmio_wr_en),
    .mmio_wr_addr  (mmio_wr_addr),
    .mmio_wr_data  (mmio_wr_data),
    .mmio_rd_en    (mmio_rd_en),
    .mmio_rd_addr  (mmio_rd_addr),
    .mmio_rd_data  (mmio_rd_data),
    .mmio_rd_valid (mmio_rd_valid),
    .dma_rd_go     (dma_rd_go),
    .dma_rd_addr   (dma_rd_addr),
    .dma_rd_size   (dma_rd_size),
    .dma_rd_en     (dma_rd_en),
    .dma_rd_empty  (dma_rd_empty),
    .dma_rd_data   (dma_rd_data),
    .dma_wr_go     (dma_wr_go),
    .dma_wr_addr   (dma_wr_addr),
    .dma_wr_size   (dma_wr_size),
    .dma_wr_en     (dma_wr_en),
    .dma_wr_full   (dma_wr_full),
    .dma_wr_data   (dma_wr_data),
    .dma_wr_done   (dma_wr_done)
  );

  // ========================================
  // DMA memory model
  // ========================================

  always @(posedge clk) begin : dma_model
    host_addr_t base_nxt;
    line_cnt_t  pos_nxt;
    line_cnt_t  left_nxt;
    base_nxt = rd_base;
    pos_nxt  = rd_pos;
    left_nxt = rd_left;
    // One step per cycle only while stressing
    if (stress) begin
      rng = lcg_next(rng);
    end
    // Read stream from the source array
    if (dma_rd_go) begin
      base_nxt     = dma_rd_addr;
      pos_nxt      = '0;
      left_nxt     = dma_rd_size;
      rd_addr_seen <= dma_rd_addr;
      rd_size_seen <= dma_rd_size;
      rd_go_cnt    <= rd_go_cnt + 1'b1;
    end else if (dma_rd_en) begin
      if (dma_rd_empty) begin
        errors++;
        $display("DMA read enable raised while the read stream was empty");
      end else begin
        pos_nxt  = rd_pos + 1'b1;
        left_nxt = rd_left - 1'b1;
      end
    end
    rd_base      <= base_nxt;
    rd_pos       <= pos_nxt;
    rd_left      <= left_nxt;
    dma_rd_data  <= src[src_idx_t'(base_nxt + host_addr_t'(pos_nxt))];
    dma_rd_empty <= (left_nxt == '0) || (stress && rng[20]);
    dma_wr_full  <= stress && rng[27];
    // Write stream into the sink
    dma_wr_done <= 1'b0;
    if (dma_wr_go) begin
      wr_addr_seen <= dma_wr_addr;
      wr_size_seen <= dma_wr_size;
      wr_go_cnt    <= wr_go_cnt + 1'b1;
      sink_cnt     <= '0;
    end else if (dma_wr_en) begin
      if (dma_wr_full) begin
        errors++;
        $display("DMA write enable raised while the write stream was full");
      end else begin
        if (sink_cnt < line_cnt_t'(SINK_DEPTH)) begin
          sink[sink_cnt] <= dma_wr_data;
        end
        sink_cnt <= sink_cnt + 1'b1;
        // Done pulse after the last line
        if (sink_cnt + 1'b1 == wr_size_seen) begin
          dma_wr_done <= 1'b1;
        end
      end
    end
  end

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    mmio_wr_en   = 1'b0;
    mmio_wr_addr = '0;
    mmio_wr_data = '0;
    mmio_rd_en   = 1'b0;
    mmio_rd_addr = '0;
    dma_rd_empty = 1'b1;
    dma_rd_data  = '0;
    dma_wr_full  = 1'b0;
    dma_wr_done  = 1'b0;
    // Source lines from four LCG words each
    for (int i = 0; i < SRC_DEPTH; i++) begin
      for (int w = 0; w < 4; w++) begin
        rng = lcg_next(rng);
        src[i][w*32 +: 32] = rng;
      end
    end
    wait (rst_n === 1'b1);
    @(posedge clk);
    register_readback();
    basic_job();
    full_load_job();
    stressed_job();
    illegal_sizes();
    back_to_back_jobs();
    repeat (4) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Ends a hung run
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d clock cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// Testbench clock and reset
`default_nettype none
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 40 ns clock period
  localparam int HALF_PERIOD  = 20;
  // Reset held over the first cycles
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Released on a rising edge, like every other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verilog/rta.sv
// Ray-tracing accelerator memory core
`default_nettype none
`timescale 1ns/10ps

module rta (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // MMIO port
  input  wire logic                    mmio_wr_en,
  input  wire rta_host_pkg::mmio_addr_t mmio_wr_addr,
  input  wire rta_host_pkg::mmio_data_t mmio_wr_data,
  input  wire logic                    mmio_rd_en,
  input  wire rta_host_pkg::mmio_addr_t mmio_rd_addr,
  output rta_host_pkg::mmio_data_t     mmio_rd_data,
  output logic                         mmio_rd_valid,
  // DMA read port
  output logic                         dma_rd_go,
  output rta_host_pkg::host_addr_t     dma_rd_addr,
  output rta_host_pkg::line_cnt_t      dma_rd_size,
  output logic                         dma_rd_en,
  input  wire logic                    dma_rd_empty,
  input  wire rta_geom_pkg::line_t     dma_rd_data,
  // DMA write port
  output logic                         dma_wr_go,
  output rta_host_pkg::host_addr_t     dma_wr_addr,
  output rta_host_pkg::line_cnt_t      dma_wr_size,
  output logic                         dma_wr_en,
  input  wire logic                    dma_wr_full,
  output rta_geom_pkg::line_t          dma_wr_data,
  input  wire logic                    dma_wr_done
);

  import rta_geom_pkg::*;

  // ========================================
  // Controller to stack memory
  // ========================================

  logic      host_we;
  logic      host_re;
  bank_sel_t host_bank;
  bank_idx_t host_idx;
  line_t     host_wdata;
  line_t     host_rdata;
  logic      host_rd_rdy;

  // Controller to filler handshake
  logic fill_req;
  logic fill_ack;

  // Filler to stack memory
  logic [NUM_RT-1:0] core_we;
  bank_idx_t         core_idx;
  line_t             core_wdata [NUM_RT];

  mem_controller memory_controller (
    .clk           (clk),
    .rst_n         (rst_n),
    .mmio_wr_en    (mmio_wr_en),
    .mmio_wr_addr  (mmio_wr_addr),
    .mmio_wr_data  (mmio_wr_data),
    .mmio_rd_en    (mmio_rd_en),
    .mmio_rd_addr  (mmio_rd_addr),
    .mmio_rd_data  (mmio_rd_data),
    .mmio_rd_valid (mmio_rd_valid),
    .dma_rd_go     (dma_rd_go),
    .dma_rd_addr   (dma_rd_addr),
    .dma_rd_size   (dma_rd_size),
    .dma_rd_en     (dma_rd_en),
    .dma_rd_empty  (dma_rd_empty),
    .dma_rd_data   (dma_rd_data),
    .dma_wr_go     (dma_wr_go),
    .dma_wr_addr   (dma_wr_addr),
    .dma_wr_size   (dma_wr_size),
    .dma_wr_en     (dma_wr_en),
    .dma_wr_full   (dma_wr_full),
    .dma_wr_data   (dma_wr_data),
    .dma_wr_done   (dma_wr_done),
    .host_we       (host_we),
    .host_re       (host_re),
    .host_bank     (host_bank),
    .host_idx      (host_idx),
    .host_wdata    (host_wdata),
    .host_rdata    (host_rdata),
    .host_rd_rdy   (host_rd_rdy),
    .fill_req      (fill_req),
    .fill_ack      (fill_ack)
  );

  // Stack banks, one per core
  mem_main memory_stack (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_we     (host_we),
    .host_re     (host_re),
    .host_bank   (host_bank),
    .host_idx    (host_idx),
    .host_wdata  (host_wdata),
    .core_we     (core_we),
    .core_idx    (core_idx),
    .core_wdata  (core_wdata),
    .host_rdata  (host_rdata),
    .host_rd_rdy (host_rd_rdy)
  );

  // Sole driver of the core port
  stack_fill stack_filler (
    .clk        (clk),
    .rst_n      (rst_n),
    .fill_req   (fill_req),
    .fill_ack   (fill_ack),
    .core_we    (core_we),
    .core_idx   (core_idx),
    .core_wdata (core_wdata)
  );

endmodule

`default_nettype wire

// File: verilog/mem_controller.sv
// Memory controller and DMA sequencer
`default_nettype none
`timescale 1ns/10ps

module mem_controller (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // MMIO port
  input  wire logic                    mmio_wr_en,
  input  wire rta_host_pkg::mmio_addr_t mmio_wr_addr,
  input  wire rta_host_pkg::mmio_data_t mmio_wr_data,
  input  wire logic                    mmio_rd_en,
  input  wire rta_host_pkg::mmio_addr_t mmio_rd_addr,
  output rta_host_pkg::mmio_data_t     mmio_rd_data,
  output logic                         mmio_rd_valid,
  // DMA read port
  output logic                         dma_rd_go,
  output rta_host_pkg::host_addr_t     dma_rd_addr,
  output rta_host_pkg::line_cnt_t      dma_rd_size,
  output logic                         dma_rd_en,
  input  wire logic                    dma_rd_empty,
  input  wire rta_geom_pkg::line_t     dma_rd_data,
  // DMA write port
  output logic                         dma_wr_go,
  output rta_host_pkg::host_addr_t     dma_wr_addr,
  output rta_host_pkg::line_cnt_t      dma_wr_size,
  output logic                         dma_wr_en,
  input  wire logic                    dma_wr_full,
  output rta_geom_pkg::line_t          dma_wr_data,
  input  wire logic                    dma_wr_done,
  // Host port of the stack memory
  output logic                         host_we,
  output logic                         host_re,
  output rta_geom_pkg::bank_sel_t      host_bank,
  output rta_geom_pkg::bank_idx_t      host_idx,
  output rta_geom_pkg::line_t          host_wdata,
  input  wire rta_geom_pkg::line_t     host_rdata,
  input  wire logic                    host_rd_rdy,
  // Filler handshake
  output logic                         fill_req,
  input  wire logic                    fill_ack
);

  import rta_geom_pkg::*;
  import rta_host_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    FILL,
    WB_GO,
    WRITEBACK,
    FINISH
  } mc_state_t;

  mc_state_t state;

  // MMIO registers
  host_addr_t rd_addr_q;
  host_addr_t wr_addr_q;
  line_cnt_t  size_q;
  logic       st_done;
  logic       st_err;

  // Job counters
  line_cnt_t load_cnt;
  line_cnt_t rd_cnt;
  line_cnt_t wr_cnt;
  line_cnt_t wb_total;
  // Frame number during writeback
  line_cnt_t fill_off;

  // Single line buffer for writeback
  line_t buf_line;
  logic  buf_full;

  logic go_wr;
  logic size_bad;
  logic rd_issue;

  assign go_wr    = mmio_wr_en && (mmio_wr_addr == REG_GO);
  assign size_bad = (size_q == '0) || (size_q > MAX_LOAD);
  // Loaded lines plus all frames
  assign wb_total = size_q + line_cnt_t'(FILL_TOTAL);
  assign fill_off = rd_cnt - size_q;

  // ========================================
  // MMIO registers
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr_q <= '0;
      wr_addr_q <= '0;
      size_q    <= '0;
    end else if (mmio_wr_en) begin
      case (mmio_wr_addr)
        REG_RD_ADDR: rd_addr_q <= host_addr_t'(mmio_wr_data);
        REG_WR_ADDR: wr_addr_q <= host_addr_t'(mmio_wr_data);
        REG_SIZE:    size_q    <= line_cnt_t'(mmio_wr_data);
        default: ;
      endcase
    end
  end

  // Read data one cycle after the request
  always_ff @(posedge clk) begin
    if (mmio_rd_en) begin
      // Unmapped offsets and GO read as zero
      mmio_rd_data <= '0;
      case (mmio_rd_addr)
        REG_RD_ADDR: mmio_rd_data <= mmio_data_t'(rd_addr_q);
        REG_WR_ADDR: mmio_rd_data <= mmio_data_t'(wr_addr_q);
        REG_SIZE:    mmio_rd_data <= mmio_data_t'(size_q);
        REG_STATUS: begin
          mmio_rd_data[ST_DONE] <= st_done;
          mmio_rd_data[ST_ERR]  <= st_err;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mmio_rd_valid <= 1'b0;
    end else begin
      mmio_rd_valid <= mmio_rd_en;
    end
  end

  // ========================================
  // Job sequencer
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      st_done   <= 1'b0;
      st_err    <= 1'b0;
      dma_rd_go <= 1'b0;
      dma_wr_go <= 1'b0;
      fill_req  <= 1'b0;
      load_cnt  <= '0;
      rd_cnt    <= '0;
      wr_cnt    <= '0;
      buf_full  <= 1'b0;
    end else begin
      // Go strobes last one cycle
      dma_rd_go <= 1'b0;
      dma_wr_go <= 1'b0;
      case (state)
        IDLE: begin
          // Go is ignored while a job runs
          if (go_wr) begin
            st_done <= size_bad;
            st_err  <= size_bad;
            if (!size_bad) begin
              dma_rd_go <= 1'b1;
              load_cnt  <= '0;
              state     <= LOAD;
            end
          end
        end
        LOAD: begin
          if (dma_rd_en) begin
            load_cnt <= load_cnt + 1'b1;
            if (load_cnt == size_q - 1'b1) begin
              state <= FILL;
            end
          end
        end
        FILL: begin
          // Host port idle here, so the filler owns the banks
          if (fill_req && fill_ack) begin
            fill_req <= 1'b0;
            state    <= WB_GO;
          end else if (!fill_req && !fill_ack) begin
            fill_req <= 1'b1;
          end
        end
        WB_GO: begin
          // Finish the handshake before writeback
          if (!fill_ack) begin
            dma_wr_go <= 1'b1;
            rd_cnt    <= '0;
            wr_cnt    <= '0;
            buf_full  <= 1'b0;
            state     <= WRITEBACK;
          end
        end
        WRITEBACK: begin
          if (rd_issue) begin
            rd_cnt <= rd_cnt + 1'b1;
          end
          // Fill and drain never meet in one cycle
          if (host_rd_rdy) begin
            buf_full <= 1'b1;
          end else if (dma_wr_en) begin
            buf_full <= 1'b0;
          end
          if (dma_wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_cnt == wb_total - 1'b1) begin
              state <= FINISH;
            end
          end
        end
        FINISH: begin
          if (dma_wr_done) begin
            st_done <= 1'b1;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Line buffer payload
  always_ff @(posedge clk) begin
    if (host_rd_rdy) begin
      buf_line <= host_rdata;
    end
  end

  // ========================================
  // DMA and host port drive
  // ========================================

  assign dma_rd_addr = rd_addr_q;
  assign dma_rd_size = size_q;
  assign dma_wr_addr = wr_addr_q;
  assign dma_wr_size = wb_total;

  assign dma_rd_en   = (state == LOAD) && !dma_rd_empty;
  assign dma_wr_en   = (state == WRITEBACK) && buf_full && !dma_wr_full;
  assign dma_wr_data = buf_line;

  // Bank read only into an empty buffer with nothing in flight
  assign rd_issue = (state == WRITEBACK) && !buf_full && !host_rd_rdy &&
                    (rd_cnt != wb_total);

  // Load data goes straight to the banks
  assign host_wdata = dma_rd_data;

  always_comb begin
    host_we   = 1'b0;
    host_re   = 1'b0;
    host_bank = '0;
    host_idx  = '0;
    if (state == LOAD) begin
      // Line n to bank n mod 4, index n div 4
      host_we   = dma_rd_en;
      host_bank = bank_sel_t'(load_cnt);
      host_idx  = bank_idx_t'(load_cnt >> BANK_BITS);
    end else if (state == WRITEBACK) begin
      host_re = rd_issue;
      if (rd_cnt < size_q) begin
        // Loaded lines in load order
        host_bank = bank_sel_t'(rd_cnt);
        host_idx  = bank_idx_t'(rd_cnt >> BANK_BITS);
      end else begin
        // Then frames, bank inner, step outer
        host_bank = bank_sel_t'(fill_off);
        host_idx  = bank_idx_t'(FILL_BASE) + bank_idx_t'(fill_off >> BANK_BITS);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/stack_fill.sv
// Stack frame filler
`default_nettype none
`timescale 1ns/10ps

module stack_fill (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // Four-phase handshake with the controller
  input  wire logic                 fill_req,
  output logic                      fill_ack,
  // Core port of the stack memory
  output logic [rta_geom_pkg::NUM_RT-1:0] core_we,
  output rta_geom_pkg::bank_idx_t   core_idx,
  output rta_geom_pkg::line_t       core_wdata [rta_geom_pkg::NUM_RT]
);

  import rta_geom_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    ACK
  } fill_state_t;

  fill_state_t state;

  // Frame step, also the index offset
  logic [STEP_BITS-1:0] step;

  // New request accepted
  logic start;

  assign start = (state == IDLE) && fill_req;

  // ========================================
  // Handshake FSM
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            step  <= '0;
            state <= LOAD;
          end
        end
        LOAD: begin
          step <= step + 1'b1;
          // Last frame goes out this cycle
          if (step == STEP_BITS'(FILL_LINES - 1)) begin
            state <= ACK;
          end
        end
        ACK: begin
          // Hold ack until req drops
          if (!fill_req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign fill_ack = (state == ACK);

  // ========================================
  // Frame writes
  // ========================================

  // All banks written together
  assign core_we  = {NUM_RT{state == LOAD}};
  assign core_idx = bank_idx_t'(FILL_BASE) + bank_idx_t'(step);

  // Bank b writes NUM_RT*k + b on step k
  for (genvar b = 0; b < NUM_RT; b++) begin : g_frame
    line_t frame_q;

    always_ff @(posedge clk) begin
      if (start) begin
        frame_q <= line_t'(b);
      end else if (state == LOAD) begin
        frame_q <= frame_q + line_t'(NUM_RT);
      end
    end

    assign core_wdata[b] = frame_q;
  end

endmodule

`default_nettype wire

// File: verilog/mem_main.sv
// Banked stack memory
`default_nettype none
`timescale 1ns/10ps

module mem_main (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // Host port, used by the memory controller
  input  wire logic                 host_we,
  input  wire logic                 host_re,
  input  wire rta_geom_pkg::bank_sel_t host_bank,
  input  wire rta_geom_pkg::bank_idx_t host_idx,
  input  wire rta_geom_pkg::line_t  host_wdata,
  // Core port, one write lane per bank
  input  wire logic [rta_geom_pkg::NUM_RT-1:0] core_we,
  input  wire rta_geom_pkg::bank_idx_t core_idx,
  input  wire rta_geom_pkg::line_t  core_wdata [rta_geom_pkg::NUM_RT],
  // Registered host read
  output rta_geom_pkg::line_t       host_rdata,
  output logic                      host_rd_rdy
);

  import rta_geom_pkg::*;

  // Per bank host selection
  logic [NUM_RT-1:0] host_hit;

  // Line at host_idx in every bank
  line_t bank_rd [NUM_RT];

  // ========================================
  // Bank arrays
  // ========================================

  for (genvar b = 0; b < NUM_RT; b++) begin : g_bank
    line_t mem [BANK_DEPTH];

    // Host read or write claims this bank
    assign host_hit[b] = (host_we || host_re) && (host_bank == bank_sel_t'(b));

    always_ff @(posedge clk) begin
      if (host_hit[b]) begin
        // Host has priority
        if (host_we) begin
          mem[host_idx] <= host_wdata;
        end
      end else if (core_we[b]) begin
        mem[core_idx] <= core_wdata[b];
      end
    end

    assign bank_rd[b] = mem[host_idx];
  end

  // ========================================
  // Host read path
  // ========================================

  // Data one cycle after the request
  always_ff @(posedge clk) begin
    if (host_re) begin
      host_rdata <= bank_rd[host_bank];
    end
  end

  // Valid strobe for host_rdata
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_rd_rdy <= 1'b0;
    end else begin
      host_rd_rdy <= host_re;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rta_host_pkg.sv
// Host side register map
`default_nettype none

package rta_host_pkg;

  // ========================================
  // Host types
  // ========================================

  // Virtual address of one line in host memory
  typedef logic [31:0] host_addr_t;

  // Line count of a DMA transfer
  typedef logic [15:0] line_cnt_t;

  // MMIO register offset and data word
  typedef logic [3:0]  mmio_addr_t;
  typedef logic [31:0] mmio_data_t;

  // ========================================
  // MMIO register map
  // ========================================

  // Any write here starts a job
  localparam mmio_addr_t REG_GO      = 4'd0;
  localparam mmio_addr_t REG_RD_ADDR = 4'd1;
  localparam mmio_addr_t REG_WR_ADDR = 4'd2;
  // Lines to load
  localparam mmio_addr_t REG_SIZE    = 4'd3;
  // Read only
  localparam mmio_addr_t REG_STATUS  = 4'd4;

  // Loaded lines must fit below the frame area of every bank
  localparam line_cnt_t MAX_LOAD =
    line_cnt_t'(rta_geom_pkg::NUM_RT * rta_geom_pkg::FILL_BASE);

  // ========================================
  // Status bits
  // ========================================

  // Job finished, cleared by the next go
  localparam int ST_DONE = 0;
  // Size rejected, no DMA traffic
  localparam int ST_ERR  = 1;

endpackage

`default_nettype wire

// File: verilog/rta_geom_pkg.sv
// Stack geometry definitions
`default_nettype none

package rta_geom_pkg;

  // ========================================
  // Core and bank geometry
  // ========================================

  // One stack bank per ray-tracing core
  localparam int NUM_RT = 4;
  localparam int BANK_BITS = $clog2(NUM_RT);

  // Lines held in each bank
  localparam int BANK_DEPTH = 16;
  localparam int IDX_BITS = $clog2(BANK_DEPTH);

  // Stack cache line width
  localparam int LINE_BITS = 128;

  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [BANK_BITS-1:0] bank_sel_t;
  typedef logic [IDX_BITS-1:0]  bank_idx_t;

  // ========================================
  // Frame pattern
  // ========================================

  // Frames start halfway up each bank
  localparam int FILL_BASE = 8;

  // Frames per bank, one per filler step
  localparam int FILL_LINES = 8;
  localparam int STEP_BITS = $clog2(FILL_LINES);

  // Frames written over all banks
  localparam int FILL_TOTAL = NUM_RT * FILL_LINES;

endpackage

`default_nettype wire
